/* combohash.sv */
// hash sequencer top, wires the sequencer, both channels and the hash RAM together
`default_nettype none

module combohash (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  hash_pkg::run_cfg_t   cfg,
    input  logic                 hash_done,
    input  hash_pkg::ram_req_t   eng_req,
    input  hash_pkg::word_t      ext_rdata,
    output logic                 busy,
    output logic                 done,
    output logic                 hmac_pass,
    output logic                 hmac_fail,
    output logic                 hash_start,
    output logic                 hash_first,
    output hash_pkg::hash_type_e hash_type,
    output hash_pkg::word_t      eng_rdata,
    output logic                 ext_rd,
    output hash_pkg::ext_addr_t  ext_raddr,
    output logic                 ext_wr,
    output hash_pkg::ext_addr_t  ext_waddr,
    output hash_pkg::word_t      ext_wdata
);
    import hash_pkg::*;

    logic       load_start;
    logic       load_done;
    logic       store_start;
    logic       store_done;
    logic       chk_pass;
    logic       chk_fail;
    xfer_cfg_t  load_cfg;
    xfer_cfg_t  store_cfg;
    load_mode_e load_mode;
    ram_req_t   load_req;
    ram_req_t   store_req;

    hash_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cfg         (cfg),
        .load_done   (load_done),
        .store_done  (store_done),
        .hash_done   (hash_done),
        .chk_pass    (chk_pass),
        .chk_fail    (chk_fail),
        .busy        (busy),
        .done        (done),
        .hmac_pass   (hmac_pass),
        .hmac_fail   (hmac_fail),
        .hash_start  (hash_start),
        .hash_first  (hash_first),
        .hash_type   (hash_type),
        .load_start  (load_start),
        .load_cfg    (load_cfg),
        .load_mode   (load_mode),
        .store_start (store_start),
        .store_cfg   (store_cfg)
    );

    hash_load_chnl u_load (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_start (load_start),
        .load_cfg   (load_cfg),
        .load_mode  (load_mode),
        .ext_rdata  (ext_rdata),
        .ram_rdata  (eng_rdata),
        .ext_rd     (ext_rd),
        .ext_raddr  (ext_raddr),
        .load_req   (load_req),
        .load_done  (load_done),
        .chk_pass   (chk_pass),
        .chk_fail   (chk_fail)
    );

    hash_store_chnl u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_start (store_start),
        .store_cfg   (store_cfg),
        .ram_rdata   (eng_rdata),
        .store_req   (store_req),
        .ext_wr      (ext_wr),
        .ext_waddr   (ext_waddr),
        .ext_wdata   (ext_wdata),
        .store_done  (store_done)
    );

    // read data is shared by the engine and both channels
    hash_ram u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .eng_req   (eng_req),
        .load_req  (load_req),
        .store_req (store_req),
        .ram_rdata (eng_rdata)
    );

endmodule

`default_nettype wire

/* combohash_input.txt */
# T func blk_cnt first chk msg_ptr hout_ptr key_ptr scrt_ptr, F addr count base step preloads memory
# X addr count base step expects output words, K check result 0 none 1 pass 2 fail, G runs, all hex
T 0 0 1 0 0100 0200 0000 0000
F 0100 10 1 1
X 0200 8 a 2
K 0
G
T 1 2 0 0 0400 0300 0000 0000
F 0300 10 100 0
F 0400 60 1 1
X 0300 10 1f6 6
K 0
G
T 2 0 1 0 0600 0280 0500 0000
F 0500 10 0 0
F 0600 10 1 1
X 0280 8 6c6c6c76 2
K 0
G
T 3 0 1 0 0000 0700 0500 0000
F 0700 8 10 1
X 0700 1 38b8b8c8 0
X 0701 6 b8b8b8c9 1
X 0707 1 b8b8bbcf 0
K 0
G
T 3 0 1 1 0000 0700 0500 0800
F 0700 8 10 1
F 0800 1 38b8b8c8 0
F 0801 6 b8b8b8c9 1
F 0807 1 b8b8bbcf 0
K 1
G
F 0803 1 0 0
K 2
G

/* combohash_properties.sv */
// concurrent checks on the sequencer top ports, bound into every combohash instance
`default_nettype none

module combohash_properties (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic hmac_pass,
    input logic hmac_fail,
    input logic hash_start,
    input logic ext_rd,
    input logic ext_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    // engine runs never overlap external traffic
    a_start_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        hash_start |-> !(ext_rd || ext_wr))
        else $error("hash_start overlaps an external memory access");

    a_result_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(hmac_pass && hmac_fail))
        else $error("hmac_pass and hmac_fail high together");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    a_wr_busy: assert property (@(posedge clk) disable iff (!rst_n)
        ext_wr |-> busy)
        else $error("ext_wr seen while the sequencer is idle");

endmodule

bind combohash combohash_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .done       (done),
    .hmac_pass  (hmac_pass),
    .hmac_fail  (hmac_fail),
    .hash_start (hash_start),
    .ext_rd     (ext_rd),
    .ext_wr     (ext_wr)
);

`default_nettype wire

/* combohash_tb.sv */
// drives combohash with the vectors of combohash_input.txt through memory and engine models
`default_nettype none

module combohash_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hash_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       start;
    run_cfg_t   cfg;
    logic       hash_done;
    ram_req_t   eng_req;
    word_t      ext_rdata;
    logic       busy;
    logic       done;
    logic       hmac_pass;
    logic       hmac_fail;
    logic       hash_start;
    logic       hash_first;
    hash_type_e hash_type;
    word_t      eng_rdata;
    logic       ext_rd;
    ext_addr_t  ext_raddr;
    logic       ext_wr;
    ext_addr_t  ext_waddr;
    word_t      ext_wdata;

    word_t      ext_mem [65536];
    logic       pend_rd;
    ext_addr_t  pend_addr;
    int         wr_cnt;
    int         err_cnt;
    int         fail_tests;
    int         test_cnt;
    int         eng_runs;
    int         cycles;
    int         cycle_limit;
    run_cfg_t   cur_cfg;
    int         exp_chk;
    ext_addr_t  exp_addr [$];
    word_t      exp_data [$];

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    combohash combohash_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .hash_done  (hash_done),
        .eng_req    (eng_req),
        .ext_rdata  (ext_rdata),
        .busy       (busy),
        .done       (done),
        .hmac_pass  (hmac_pass),
        .hmac_fail  (hmac_fail),
        .hash_start (hash_start),
        .hash_first (hash_first),
        .hash_type  (hash_type),
        .eng_rdata  (eng_rdata),
        .ext_rd     (ext_rd),
        .ext_raddr  (ext_raddr),
        .ext_wr     (ext_wr),
        .ext_waddr  (ext_waddr),
        .ext_wdata  (ext_wdata)
    );

    // external memory sampled mid-cycle with read data one cycle later
    always @(negedge clk) begin
        if (ext_wr) begin
            ext_mem[ext_waddr] = ext_wdata;
            wr_cnt = wr_cnt + 1;
        end
        pend_rd   = ext_rd;
        pend_addr = ext_raddr;
    end

    always @(posedge clk) begin
        #1;
        if (pend_rd) begin
            ext_rdata = ext_mem[pend_addr];
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if ((cycle_limit != 0) && (cycles > cycle_limit)) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic report_word(input string name, input word_t exp_v, input word_t got_v);
        if (exp_v !== got_v) begin
            $display("[ERROR] %s exp=%h got=%h", name, exp_v, got_v);
            err_cnt = err_cnt + 1;
        end
    endtask

    // engine model adds both message halves into the state
    task automatic emulate_engine();
        word_t buf_w [48];
        int    st_len;
        int    n;
        int    dly;
        logic  wide;
        logic  first;
        word_t old_w;
        wide  = (cur_cfg.func == HF_SHA512) || (cur_cfg.func == HF_HMAC512_PASS1) ||
                (cur_cfg.func == HF_HMAC512_PASS2);
        // only the opening engine run of a first hash or a pass 2 starts from zero
        first = (eng_runs == 0) &&
                (cur_cfg.first_hash || (cur_cfg.func == HF_HMAC256_PASS2) ||
                 (cur_cfg.func == HF_HMAC512_PASS2));
        report_word("hash_type", 32'(wide), 32'(hash_type));
        report_word("hash_first", 32'(first), 32'(hash_first));
        eng_runs = eng_runs + 1;
        st_len   = wide ? 16 : 8;
        n        = 3 * st_len;
        dly      = 1 + int'($urandom % 8);
        repeat (dly) @(posedge clk);
        for (int k = 0; k <= n; k++) begin
            @(posedge clk);
            #1;
            if (k > 0) begin
                buf_w[k - 1] = eng_rdata;
            end
            eng_req = '0;
            if (k < st_len) begin
                eng_req.rd   = 1'b1;
                eng_req.addr = RAM_ST_BASE + ram_addr_t'(k);
            end else if (k < n) begin
                eng_req.rd   = 1'b1;
                eng_req.addr = RAM_MSG_BASE + ram_addr_t'(k - st_len);
            end
        end
        for (int i = 0; i < st_len; i++) begin
            @(posedge clk);
            #1;
            old_w         = first ? 32'h0 : buf_w[i];
            eng_req.rd    = 1'b0;
            eng_req.wr    = 1'b1;
            eng_req.addr  = RAM_ST_BASE + ram_addr_t'(i);
            eng_req.wdata = old_w + buf_w[st_len + i] + buf_w[2 * st_len + i];
        end
        @(posedge clk);
        #1;
        eng_req   = '0;
        hash_done = 1'b1;
        @(posedge clk);
        #1;
        hash_done = 1'b0;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (hash_start) begin
                emulate_engine();
            end
        end
    end

    task automatic run_test();
        int   errs_before;
        logic got_pass;
        logic got_fail;
        errs_before = err_cnt;
        got_pass    = 1'b0;
        got_fail    = 1'b0;
        wr_cnt      = 0;
        eng_runs    = 0;
        @(posedge clk);
        #1;
        start = 1'b1;
        cfg   = cur_cfg;
        @(posedge clk);
        #1;
        start = 1'b0;
        report_word("busy", 32'h1, 32'(busy));
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            if (hmac_pass) begin
                got_pass = 1'b1;
            end
            if (hmac_fail) begin
                got_fail = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        report_word("busy", 32'h0, 32'(busy));
        foreach (exp_addr[i]) begin
            report_word($sformatf("ext_mem[%h]", exp_addr[i]), exp_data[i],
                        ext_mem[exp_addr[i]]);
        end
        report_word("hmac_pass", 32'(exp_chk == 1), 32'(got_pass));
        report_word("hmac_fail", 32'(exp_chk == 2), 32'(got_fail));
        if ((exp_chk != 0) && (wr_cnt != 0)) begin
            $display("external memory was written %0d times during a check run", wr_cnt);
            err_cnt = err_cnt + 1;
        end
        test_cnt = test_cnt + 1;
        if (err_cnt == errs_before) begin
            $display("test %0d func %0d: ok", test_cnt, cur_cfg.func);
        end else begin
            $display("test %0d func %0d: failed", test_cnt, cur_cfg.func);
            fail_tests = fail_tests + 1;
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic check_reset();
        wait (rst_n === 1'b1);
        @(posedge clk);
        #1;
        report_word("busy", 32'h0, 32'(busy));
        report_word("done", 32'h0, 32'(done));
        report_word("hmac_pass", 32'h0, 32'(hmac_pass));
        report_word("hmac_fail", 32'h0, 32'(hmac_fail));
        report_word("ext_rd", 32'h0, 32'(ext_rd));
        report_word("ext_wr", 32'h0, 32'(ext_wr));
        if (err_cnt == 0) begin
            $display("reset test: ok");
        end else begin
            $display("reset test: failed");
            fail_tests = fail_tests + 1;
        end
    endtask

    task automatic process_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [31:0] f6;
        logic [31:0] f7;
        fd = $fopen("combohash_input.txt", "r");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if ((code > 1) && (line[0] != "#")) begin
                f0 = 0;
                f1 = 0;
                f2 = 0;
                f3 = 0;
                f4 = 0;
                f5 = 0;
                f6 = 0;
                f7 = 0;
                code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h %h",
                               f0, f1, f2, f3, f4, f5, f6, f7);
                if (line[0] == "T") begin
                    cur_cfg.func       = hash_func_e'(f0[2:0]);
                    cur_cfg.blk_cnt    = f1[15:0];
                    cur_cfg.first_hash = f2[0];
                    cur_cfg.secret_chk = f3[0];
                    cur_cfg.msg_ptr    = f4[15:0];
                    cur_cfg.hout_ptr   = f5[15:0];
                    cur_cfg.key_ptr    = f6[15:0];
                    cur_cfg.scrt_ptr   = f7[15:0];
                end else if (line[0] == "F") begin
                    for (int k = 0; k < int'(f1); k++) begin
                        ext_mem[f0[15:0] + k[15:0]] = f2 + f3 * k;
                    end
                end else if (line[0] == "X") begin
                    for (int k = 0; k < int'(f1); k++) begin
                        exp_addr.push_back(f0[15:0] + k[15:0]);
                        exp_data.push_back(f2 + f3 * k);
                    end
                end else if (line[0] == "K") begin
                    exp_chk = int'(f0);
                end else if (line[0] == "G") begin
                    run_test();
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int    fd;
        int    code;
        int    n_runs;
        int    a;
        string line;
        start       = 1'b0;
        cfg         = '0;
        hash_done   = 1'b0;
        eng_req     = '0;
        ext_rdata   = '0;
        pend_rd     = 1'b0;
        pend_addr   = '0;
        wr_cnt      = 0;
        err_cnt     = 0;
        fail_tests  = 0;
        test_cnt    = 0;
        eng_runs    = 0;
        cycles      = 0;
        cycle_limit = 0;
        exp_chk     = 0;
        cur_cfg     = '0;
        void'($urandom(37));
        for (a = 0; a < 65536; a++) begin
            ext_mem[a] = {~a[15:0], a[15:0]};
        end

        // first pass only counts the runs for the cycle limit
        n_runs = 0;
        fd = $fopen("combohash_input.txt", "r");
        if (fd == 0) begin
            $display("could not open combohash_input.txt");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if ((code > 0) && (line[0] == "G")) begin
                    n_runs = n_runs + 1;
                end
            end
            $fclose(fd);
            cycle_limit = 16 + 400 * (n_runs + 1);

            check_reset();
            process_vectors();

            $display("tests %0d, failed tests %0d, errors %0d",
                     test_cnt + 1, fail_tests, err_cnt);
            if ((err_cnt == 0) && (fail_tests == 0)) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hash_load_chnl.sv */
// input channel, copies, key-pads, pads or checks external words against the hash RAM
`default_nettype none

module hash_load_chnl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load_start,
    input  hash_pkg::xfer_cfg_t  load_cfg,
    input  hash_pkg::load_mode_e load_mode,
    input  hash_pkg::word_t      ext_rdata,
    input  hash_pkg::word_t      ram_rdata,
    output logic                 ext_rd,
    output hash_pkg::ext_addr_t  ext_raddr,
    output hash_pkg::ram_req_t   load_req,
    output logic                 load_done,
    output logic                 chk_pass,
    output logic                 chk_fail
);
    import hash_pkg::*;

    xfer_cfg_t  cfg_q;
    load_mode_e mode_q;
    logic       busy;
    ram_addr_t  idx;
    logic       wr_vld;
    logic       wr_last;
    ram_addr_t  wr_idx;
    logic       match;
    logic       pair_eq;
    logic       is_check;
    logic [5:0] st_len;
    word_t      pad_word;

    assign is_check = (mode_q == LM_CHECK);
    assign st_len   = cfg_q.len >> 1;
    assign pair_eq  = (ext_rdata == ram_rdata);

    // pad slots are counted but never read from outside
    assign ext_rd    = busy && !((mode_q == LM_PASS1_PAD) && (idx >= st_len));
    assign ext_raddr = cfg_q.ext_addr + ext_addr_t'(idx);

    always_ff @(posedge clk) begin
        if (load_start) begin
            cfg_q  <= load_cfg;
            mode_q <= load_mode;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (load_start) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            if (idx == cfg_q.len - 6'd1) begin
                busy <= 1'b0;
            end
            idx <= idx + 6'd1;
        end
    end

    // write stage, one cycle behind the read slot
    always_ff @(posedge clk) begin
        wr_idx  <= idx;
        wr_last <= (idx == cfg_q.len - 6'd1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_vld    <= 1'b0;
            load_done <= 1'b0;
            chk_pass  <= 1'b0;
            chk_fail  <= 1'b0;
            match     <= 1'b1;
        end else begin
            wr_vld    <= busy;
            load_done <= wr_vld && wr_last;
            chk_pass  <= wr_vld && wr_last && is_check && match && pair_eq;
            chk_fail  <= wr_vld && wr_last && is_check && !(match && pair_eq);
            if (load_start) begin
                match <= 1'b1;
            end else if (wr_vld && !pair_eq) begin
                match <= 1'b0;
            end
        end
    end

    // inner hash, then 0x80000000, zeros and the bit length
    always_comb begin
        if (wr_idx < st_len) begin
            pad_word = ext_rdata;
        end else if (wr_idx == st_len) begin
            pad_word = PAD_FIRST_WORD;
        end else if (wr_last) begin
            pad_word = word_t'(cfg_q.len) * PAD_LEN_PER_WORD;
        end else begin
            pad_word = '0;
        end
    end

    always_comb begin
        load_req.rd   = busy && is_check;
        load_req.wr   = wr_vld && !is_check;
        load_req.addr = cfg_q.ram_addr + (is_check ? idx : wr_idx);
        case (mode_q)
            LM_KEY_IPAD:  load_req.wdata = ext_rdata ^ IPAD_WORD;
            LM_KEY_OPAD:  load_req.wdata = ext_rdata ^ OPAD_WORD;
            LM_PASS1_PAD: load_req.wdata = pad_word;
            default:      load_req.wdata = ext_rdata;
        endcase
    end

endmodule

`default_nettype wire

/* hash_pkg.sv */
// shared widths, hash RAM map, padding constants and types, imported by every RTL unit
`default_nettype none

package hash_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] ext_addr_t;
    typedef logic [5:0]  ram_addr_t;
    typedef logic [15:0] blk_cnt_t;

    // hash RAM map, state at the bottom and message block above it
    localparam int        RAM_WORDS    = 64;
    localparam ram_addr_t RAM_ST_BASE  = 6'd0;
    localparam ram_addr_t RAM_MSG_BASE = 6'd32;

    localparam word_t IPAD_WORD        = 32'h36363636;
    localparam word_t OPAD_WORD        = 32'h5c5c5c5c;
    localparam word_t PAD_FIRST_WORD   = 32'h80000000;
    // 16 words give 0x300, 32 words give 0x600
    localparam word_t PAD_LEN_PER_WORD = 32'd48;

    typedef enum logic [2:0] {
        HF_SHA256,
        HF_SHA512,
        HF_HMAC256_PASS1,
        HF_HMAC256_PASS2,
        HF_HMAC512_PASS1,
        HF_HMAC512_PASS2
    } hash_func_e;

    typedef enum logic {
        HT_SHA256,
        HT_SHA512
    } hash_type_e;

    typedef enum logic [3:0] {
        MFSM_IDLE,
        MFSM_LD_ST,
        MFSM_LD_KEY,
        MFSM_LD_MSG,
        MFSM_LD_PASS1,
        MFSM_LD_SECRET,
        MFSM_HF,
        MFSM_WB_HOUT,
        MFSM_DONE
    } mfsm_e;

    typedef enum logic [2:0] {
        LM_COPY,
        LM_KEY_IPAD,
        LM_KEY_OPAD,
        LM_PASS1_PAD,
        LM_CHECK
    } load_mode_e;

    typedef struct packed {
        hash_func_e func;
        blk_cnt_t   blk_cnt;
        logic       first_hash;
        logic       secret_chk;
        ext_addr_t  msg_ptr;
        ext_addr_t  hout_ptr;
        ext_addr_t  key_ptr;
        ext_addr_t  scrt_ptr;
    } run_cfg_t;

    typedef struct packed {
        ext_addr_t  ext_addr;
        ram_addr_t  ram_addr;
        logic [5:0] len;
    } xfer_cfg_t;

    typedef struct packed {
        logic      rd;
        logic      wr;
        ram_addr_t addr;
        word_t     wdata;
    } ram_req_t;

endpackage

`default_nettype wire

/* hash_ram.sv */
// single-port hash RAM shared by the engine and both channels, engine has priority
`default_nettype none

module hash_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  hash_pkg::ram_req_t eng_req,
    input  hash_pkg::ram_req_t load_req,
    input  hash_pkg::ram_req_t store_req,
    output hash_pkg::word_t    ram_rdata
);
    import hash_pkg::*;

    word_t    mem [RAM_WORDS];
    ram_req_t req;

    // engine, then load, then store
    always_comb begin
        if (eng_req.rd || eng_req.wr) begin
            req = eng_req;
        end else if (load_req.rd || load_req.wr) begin
            req = load_req;
        end else begin
            req = store_req;
        end
    end

    always_ff @(posedge clk) begin
        if (req.wr) begin
            mem[req.addr] <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_rdata <= '0;
        end else if (req.rd) begin
            ram_rdata <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

/* hash_seq.sv */
// main sequencer, latches the run config and steps loads, engine runs and write-back
`default_nettype none

module hash_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  hash_pkg::run_cfg_t   cfg,
    input  logic                 load_done,
    input  logic                 store_done,
    input  logic                 hash_done,
    input  logic                 chk_pass,
    input  logic                 chk_fail,
    output logic                 busy,
    output logic                 done,
    output logic                 hmac_pass,
    output logic                 hmac_fail,
    output logic                 hash_start,
    output logic                 hash_first,
    output hash_pkg::hash_type_e hash_type,
    output logic                 load_start,
    output hash_pkg::xfer_cfg_t  load_cfg,
    output hash_pkg::load_mode_e load_mode,
    output logic                 store_start,
    output hash_pkg::xfer_cfg_t  store_cfg
);
    import hash_pkg::*;

    run_cfg_t   cfg_q;
    mfsm_e      state;
    mfsm_e      state_nxt;
    logic       adv;
    logic       tog;
    blk_cnt_t   blk_cnt;
    blk_cnt_t   blk_nxt;
    blk_cnt_t   last_blk;
    ext_addr_t  msg_off;
    logic       is_pass1;
    logic       is_pass2;
    logic       is_load;
    logic [5:0] st_len;
    logic [5:0] msg_len;

    assign is_pass1 = (cfg_q.func == HF_HMAC256_PASS1) || (cfg_q.func == HF_HMAC512_PASS1);
    assign is_pass2 = (cfg_q.func == HF_HMAC256_PASS2) || (cfg_q.func == HF_HMAC512_PASS2);

    always_comb begin
        case (cfg_q.func)
            HF_SHA512, HF_HMAC512_PASS1, HF_HMAC512_PASS2: hash_type = HT_SHA512;
            default:                                       hash_type = HT_SHA256;
        endcase
    end

    assign st_len  = (hash_type == HT_SHA512) ? 6'd16 : 6'd8;
    assign msg_len = st_len << 1;

    // pass 1 on a first hash spends one extra block on the key
    assign last_blk   = cfg_q.blk_cnt + blk_cnt_t'(is_pass1 && cfg_q.first_hash);
    assign hash_first = (blk_cnt == '0) && (cfg_q.first_hash || is_pass2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (start && (state == MFSM_IDLE)) begin
            cfg_q <= cfg;
        end
    end

    always_comb begin
        state_nxt = state;
        blk_nxt   = blk_cnt;
        adv       = 1'b0;
        case (state)
            MFSM_IDLE: begin
                adv     = start;
                blk_nxt = '0;
                if ((cfg.func == HF_HMAC256_PASS2) || (cfg.func == HF_HMAC512_PASS2)) begin
                    state_nxt = MFSM_LD_KEY;
                end else if (!cfg.first_hash) begin
                    state_nxt = MFSM_LD_ST;
                end else if ((cfg.func == HF_HMAC256_PASS1) ||
                             (cfg.func == HF_HMAC512_PASS1)) begin
                    state_nxt = MFSM_LD_KEY;
                end else begin
                    state_nxt = MFSM_LD_MSG;
                end
            end
            MFSM_LD_ST: begin
                adv       = load_done;
                state_nxt = MFSM_LD_MSG;
            end
            MFSM_LD_KEY, MFSM_LD_MSG, MFSM_LD_PASS1: begin
                adv       = load_done;
                state_nxt = MFSM_HF;
            end
            MFSM_HF: begin
                adv = hash_done;
                if (is_pass2) begin
                    if (blk_cnt == '0) begin
                        state_nxt = MFSM_LD_PASS1;
                        blk_nxt   = blk_cnt_t'(1);
                    end else begin
                        state_nxt = cfg_q.secret_chk ? MFSM_LD_SECRET : MFSM_WB_HOUT;
                        blk_nxt   = '0;
                    end
                end else if (blk_cnt == last_blk) begin
                    state_nxt = MFSM_WB_HOUT;
                    blk_nxt   = '0;
                end else begin
                    state_nxt = MFSM_LD_MSG;
                    blk_nxt   = blk_cnt + blk_cnt_t'(1);
                end
            end
            MFSM_LD_SECRET: begin
                adv       = load_done;
                state_nxt = MFSM_DONE;
            end
            MFSM_WB_HOUT: begin
                adv       = store_done;
                state_nxt = MFSM_DONE;
            end
            MFSM_DONE: begin
                adv       = 1'b1;
                state_nxt = MFSM_IDLE;
            end
            default: begin
                adv       = 1'b1;
                state_nxt = MFSM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= MFSM_IDLE;
            blk_cnt <= '0;
            tog     <= 1'b0;
        end else begin
            tog <= adv;
            if (adv) begin
                state   <= state_nxt;
                blk_cnt <= blk_nxt;
            end
        end
    end

    // message pointer moves one block per message load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msg_off <= '0;
        end else if (state == MFSM_IDLE) begin
            msg_off <= '0;
        end else if ((state == MFSM_LD_MSG) && load_done) begin
            msg_off <= msg_off + ext_addr_t'(msg_len);
        end
    end

    assign is_load = (state == MFSM_LD_ST) || (state == MFSM_LD_KEY) ||
                     (state == MFSM_LD_MSG) || (state == MFSM_LD_PASS1) ||
                     (state == MFSM_LD_SECRET);

    // unit starts fire one cycle after the state is entered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_start  <= 1'b0;
            store_start <= 1'b0;
            hash_start  <= 1'b0;
            hmac_pass   <= 1'b0;
            hmac_fail   <= 1'b0;
        end else begin
            load_start  <= tog && is_load;
            store_start <= tog && (state == MFSM_WB_HOUT);
            hash_start  <= tog && (state == MFSM_HF);
            hmac_pass   <= chk_pass;
            hmac_fail   <= chk_fail;
        end
    end

    assign busy = (state != MFSM_IDLE);
    assign done = (state == MFSM_DONE);

    always_comb begin
        load_cfg.ext_addr = cfg_q.msg_ptr + msg_off;
        load_cfg.ram_addr = RAM_MSG_BASE;
        load_cfg.len      = msg_len;
        load_mode         = LM_COPY;
        case (state)
            MFSM_LD_ST: begin
                load_cfg.ext_addr = cfg_q.hout_ptr;
                load_cfg.ram_addr = RAM_ST_BASE;
                load_cfg.len      = st_len;
            end
            MFSM_LD_KEY: begin
                load_cfg.ext_addr = cfg_q.key_ptr;
                load_mode         = is_pass2 ? LM_KEY_OPAD : LM_KEY_IPAD;
            end
            MFSM_LD_PASS1: begin
                load_cfg.ext_addr = cfg_q.hout_ptr;
                load_mode         = LM_PASS1_PAD;
            end
            MFSM_LD_SECRET: begin
                load_cfg.ext_addr = cfg_q.scrt_ptr;
                load_cfg.ram_addr = RAM_ST_BASE;
                load_cfg.len      = st_len;
                load_mode         = LM_CHECK;
            end
            default: begin
                load_mode = LM_COPY;
            end
        endcase
    end

    assign store_cfg = '{ext_addr: cfg_q.hout_ptr, ram_addr: RAM_ST_BASE, len: st_len};

endmodule

`default_nettype wire

/* hash_store_chnl.sv */
// output channel, streams state words from the hash RAM out to external memory
`default_nettype none

module hash_store_chnl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                store_start,
    input  hash_pkg::xfer_cfg_t store_cfg,
    input  hash_pkg::word_t     ram_rdata,
    output hash_pkg::ram_req_t  store_req,
    output logic                ext_wr,
    output hash_pkg::ext_addr_t ext_waddr,
    output hash_pkg::word_t     ext_wdata,
    output logic                store_done
);
    import hash_pkg::*;

    xfer_cfg_t cfg_q;
    logic      busy;
    ram_addr_t idx;
    ram_addr_t wr_idx;
    logic      wr_last;

    always_ff @(posedge clk) begin
        if (store_start) begin
            cfg_q <= store_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (store_start) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            if (idx == cfg_q.len - 6'd1) begin
                busy <= 1'b0;
            end
            idx <= idx + 6'd1;
        end
    end

    always_ff @(posedge clk) begin
        wr_idx  <= idx;
        wr_last <= (idx == cfg_q.len - 6'd1);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ext_wr     <= 1'b0;
            store_done <= 1'b0;
        end else begin
            ext_wr     <= busy;
            store_done <= ext_wr && wr_last;
        end
    end

    // read word n while word n-1 goes out
    assign store_req.rd    = busy;
    assign store_req.wr    = 1'b0;
    assign store_req.addr  = cfg_q.ram_addr + idx;
    assign store_req.wdata = '0;

    assign ext_waddr = cfg_q.ext_addr + ext_addr_t'(wr_idx);
    assign ext_wdata = ram_rdata;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the combohash testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module combohash_tb \
    --Mdir obj_dir -o combohash_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/combohash_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "no result line in sim.log"
exit 1

/* sim.f */
hash_pkg.sv
hash_ram.sv
hash_load_chnl.sv
hash_store_chnl.sv
hash_seq.sv
combohash.sv
tb_clkgen.sv
combohash_properties.sv
combohash_tb.sv

/* tb_clkgen.sv */
// testbench clock and reset source, 8 ns period with reset held low for 16 cycles
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire
